//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Immediate field as it comes out of the instruction word
    localparam int IMM_WIDTH = 16;

    // Data path width used when the top level does not override it
    localparam int DEFAULT_DATA_WIDTH = 32;

    ////////////////////
    // Operation codes
    ////////////////////

    // One code per execute operation
    typedef enum logic [3:0] {
        // Signed add and subtract flag overflow
        OP_ADD  = 4'd0,
        OP_ADDU = 4'd1,
        OP_SUB  = 4'd2,
        OP_SUBU = 4'd3,
        // Bitwise logic
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_NOR  = 4'd7,
        // Set on less than
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        // Barrel shifter codes
        OP_SLL  = 4'd10,
        OP_SRL  = 4'd11,
        OP_SRA  = 4'd12,
        // Conditional moves of operand A
        OP_MOVZ = 4'd13,
        OP_MOVN = 4'd14
    } exec_op_t;

endpackage

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  exec_pkg::exec_op_t    op,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  overflow
);

    import exec_pkg::*;

    localparam int MSB = DATA_WIDTH - 1;

    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] diff;
    logic                  add_ovf;
    logic                  sub_ovf;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // Shared adder and subtractor for signed and unsigned forms
    assign sum  = a + b;
    assign diff = a - b;

    // Same input signs, result sign differs
    assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    // Opposite input signs, result takes the sign of b
    assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            OP_ADD: begin
                result   = sum;
                overflow = add_ovf;
            end
            OP_SUB: begin
                result   = diff;
                overflow = sub_ovf;
            end
            // Unsigned forms wrap silently
            OP_ADDU: result = sum;
            OP_SUBU: result = diff;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_NOR:  result = ~(a | b);
            // Compare result in bit 0 only
            OP_SLT:  result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            OP_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            // Moves carry a, the stage decides the write
            OP_MOVZ: result = a;
            OP_MOVN: result = a;
            // Shift codes go through the shifter instead
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/barrel_shifter.sv
`default_nettype none

module barrel_shifter #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH)
) (
    input  logic [DATA_WIDTH-1:0]  shift_in,
    input  logic [SHAMT_WIDTH-1:0] amount,
    input  exec_pkg::exec_op_t     op,
    output logic [DATA_WIDTH-1:0]  shift_out
);

    import exec_pkg::*;

    logic                  shift_left;
    logic                  fill;
    logic [DATA_WIDTH-1:0] stage [SHAMT_WIDTH+1];

    assign shift_left = (op == OP_SLL);
    // Sign bit only for arithmetic right shift
    assign fill = (op == OP_SRA) ? shift_in[DATA_WIDTH-1] : 1'b0;

    assign stage[0] = shift_in;

    // Stage i moves by 2**i when amount bit i is set
    for (genvar i = 0; i < SHAMT_WIDTH; i++) begin : g_stage
        localparam int STEP = 1 << i;
        always_comb begin
            if (!amount[i]) begin
                stage[i+1] = stage[i];
            end else if (shift_left) begin
                stage[i+1] = {stage[i][DATA_WIDTH-STEP-1:0], {STEP{1'b0}}};
            end else begin
                stage[i+1] = {{STEP{fill}}, stage[i][DATA_WIDTH-1:STEP]};
            end
        end
    end

    assign shift_out = stage[SHAMT_WIDTH];

endmodule

`default_nettype wire

//--- source/op_receiver.sv
`default_nettype none

module op_receiver #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_req,
    input  exec_pkg::exec_op_t             op,
    input  logic [DATA_WIDTH-1:0]          op_a,
    input  logic [DATA_WIDTH-1:0]          op_b,
    input  logic [exec_pkg::IMM_WIDTH-1:0] imm,
    input  logic                           imm_signed,
    input  logic                           use_imm,
    input  logic [SHAMT_WIDTH-1:0]         shamt,
    input  logic                           shamt_from_reg,
    input  logic                           op_ready,
    output logic                           in_ack,
    output logic                           op_valid,
    output exec_pkg::exec_op_t             buf_op,
    output logic [DATA_WIDTH-1:0]          buf_a,
    output logic [DATA_WIDTH-1:0]          buf_b,
    output logic [exec_pkg::IMM_WIDTH-1:0] buf_imm,
    output logic                           buf_imm_signed,
    output logic                           buf_use_imm,
    output logic [SHAMT_WIDTH-1:0]         buf_shamt,
    output logic                           buf_shamt_from_reg
);

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_t;

    state_t state;
    logic   req_q;
    logic   buf_full;
    logic   accept;
    logic   take;

    ////////////////////
    // Handshake FSM
    ////////////////////

    // Request sampled once, the FSM acts on the flopped copy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= in_req;
        end
    end

    // Rising request while idle and the buffer has room
    assign accept = (state == S_IDLE) && req_q && !buf_full;
    // Stage pulls the buffered item
    assign take = buf_full && op_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_ACK;
                    end
                end
                // Hold ack until the producer drops its request
                S_ACK: begin
                    if (!req_q) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign in_ack = (state == S_ACK);

    ////////////////////
    // One-entry buffer
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (accept) begin
            buf_full <= 1'b1;
        end else if (take) begin
            buf_full <= 1'b0;
        end
    end

    assign op_valid = buf_full;

    // Fields still held by the producer on the accept edge
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_op             <= op;
            buf_a              <= op_a;
            buf_b              <= op_b;
            buf_imm            <= imm;
            buf_imm_signed     <= imm_signed;
            buf_use_imm        <= use_imm;
            buf_shamt          <= shamt;
            buf_shamt_from_reg <= shamt_from_reg;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_stage.sv
`default_nettype none

module exec_stage #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           op_valid,
    input  exec_pkg::exec_op_t             op,
    input  logic [DATA_WIDTH-1:0]          op_a,
    input  logic [DATA_WIDTH-1:0]          op_b,
    input  logic [exec_pkg::IMM_WIDTH-1:0] imm,
    input  logic                           imm_signed,
    input  logic                           use_imm,
    input  logic [SHAMT_WIDTH-1:0]         shamt,
    input  logic                           shamt_from_reg,
    input  logic                           res_ready,
    output logic                           op_ready,
    output logic                           res_valid,
    output logic [DATA_WIDTH-1:0]          result,
    output logic                           reg_write,
    output logic                           overflow
);

    import exec_pkg::*;

    logic [DATA_WIDTH-1:0]  imm_ext;
    logic [DATA_WIDTH-1:0]  alu_b;
    logic [SHAMT_WIDTH-1:0] shift_amt;
    logic [DATA_WIDTH-1:0]  alu_result;
    logic                   alu_overflow;
    logic [DATA_WIDTH-1:0]  shift_result;
    logic                   is_shift;
    logic [DATA_WIDTH-1:0]  next_result;
    logic                   next_reg_write;
    logic                   transfer;

    ////////////////////
    // Operand select
    ////////////////////

    // Size cast keeps the sign of the signed form
    assign imm_ext = imm_signed ? DATA_WIDTH'($signed(imm)) : DATA_WIDTH'(imm);
    assign alu_b   = use_imm ? imm_ext : op_b;
    // Variable shifts take the amount from the low bits of A
    assign shift_amt = shamt_from_reg ? op_a[SHAMT_WIDTH-1:0] : shamt;

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_i (
        .a        (op_a),
        .b        (alu_b),
        .op       (op),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    barrel_shifter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) shifter_i (
        .shift_in  (op_b),
        .amount    (shift_amt),
        .op        (op),
        .shift_out (shift_result)
    );

    ////////////////////
    // Result and write
    ////////////////////

    assign is_shift    = (op == OP_SLL) || (op == OP_SRL) || (op == OP_SRA);
    assign next_result = is_shift ? shift_result : alu_result;

    // Overflow kills the write, moves test op_b
    always_comb begin
        case (op)
            OP_MOVZ: next_reg_write = (op_b == '0);
            OP_MOVN: next_reg_write = (op_b != '0);
            default: next_reg_write = !alu_overflow;
        endcase
    end

    ////////////////////
    // Stage register
    ////////////////////

    // Free now or freed by the sender this cycle
    assign op_ready = !res_valid || res_ready;
    assign transfer = op_valid && op_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (transfer) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            result    <= next_result;
            reg_write <= next_reg_write;
            overflow  <= alu_overflow;
        end
    end

endmodule

`default_nettype wire

//--- source/result_sender.sv
`default_nettype none

module result_sender #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  res_valid,
    input  logic [DATA_WIDTH-1:0] result,
    input  logic                  reg_write,
    input  logic                  overflow,
    input  logic                  out_ack,
    output logic                  res_ready,
    output logic                  out_req,
    output logic [DATA_WIDTH-1:0] out_result,
    output logic                  out_reg_write,
    output logic                  out_overflow
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_t;

    state_t state;
    logic   load;

    // New result only while nothing is on the output
    assign res_ready = (state == S_IDLE);
    assign load      = res_valid && res_ready;

    ////////////////////
    // Four-phase FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (load) begin
                        state <= S_REQ;
                    end
                end
                // Consumer has the data once ack rises
                S_REQ: begin
                    if (out_ack) begin
                        state <= S_WAIT;
                    end
                end
                // Ack must fall before the next request
                S_WAIT: begin
                    if (!out_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign out_req = (state == S_REQ);

    // Held stable for the whole request phase
    always_ff @(posedge clk) begin
        if (load) begin
            out_result    <= result;
            out_reg_write <= reg_write;
            out_overflow  <= overflow;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_req,
    input  exec_pkg::exec_op_t             op,
    input  logic [DATA_WIDTH-1:0]          op_a,
    input  logic [DATA_WIDTH-1:0]          op_b,
    input  logic [exec_pkg::IMM_WIDTH-1:0] imm,
    input  logic                           imm_signed,
    input  logic                           use_imm,
    input  logic [SHAMT_WIDTH-1:0]         shamt,
    input  logic                           shamt_from_reg,
    input  logic                           out_ack,
    output logic                           in_ack,
    output logic                           out_req,
    output logic [DATA_WIDTH-1:0]          result,
    output logic                           reg_write,
    output logic                           overflow
);

    import exec_pkg::*;

    ////////////////////
    // Internal wires
    ////////////////////

    // Receiver to stage
    logic                   op_valid;
    logic                   op_ready;
    exec_op_t               buf_op;
    logic [DATA_WIDTH-1:0]  buf_a;
    logic [DATA_WIDTH-1:0]  buf_b;
    logic [IMM_WIDTH-1:0]   buf_imm;
    logic                   buf_imm_signed;
    logic                   buf_use_imm;
    logic [SHAMT_WIDTH-1:0] buf_shamt;
    logic                   buf_shamt_from_reg;

    // Stage to sender
    logic                   res_valid;
    logic                   res_ready;
    logic [DATA_WIDTH-1:0]  st_result;
    logic                   st_reg_write;
    logic                   st_overflow;

    op_receiver #(
        .DATA_WIDTH (DATA_WIDTH)
    ) receiver_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .in_req             (in_req),
        .op                 (op),
        .op_a               (op_a),
        .op_b               (op_b),
        .imm                (imm),
        .imm_signed         (imm_signed),
        .use_imm            (use_imm),
        .shamt              (shamt),
        .shamt_from_reg     (shamt_from_reg),
        .op_ready           (op_ready),
        .in_ack             (in_ack),
        .op_valid           (op_valid),
        .buf_op             (buf_op),
        .buf_a              (buf_a),
        .buf_b              (buf_b),
        .buf_imm            (buf_imm),
        .buf_imm_signed     (buf_imm_signed),
        .buf_use_imm        (buf_use_imm),
        .buf_shamt          (buf_shamt),
        .buf_shamt_from_reg (buf_shamt_from_reg)
    );

    exec_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op             (buf_op),
        .op_a           (buf_a),
        .op_b           (buf_b),
        .imm            (buf_imm),
        .imm_signed     (buf_imm_signed),
        .use_imm        (buf_use_imm),
        .shamt          (buf_shamt),
        .shamt_from_reg (buf_shamt_from_reg),
        .res_ready      (res_ready),
        .op_ready       (op_ready),
        .res_valid      (res_valid),
        .result         (st_result),
        .reg_write      (st_reg_write),
        .overflow       (st_overflow)
    );

    result_sender #(
        .DATA_WIDTH (DATA_WIDTH)
    ) sender_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .result        (st_result),
        .reg_write     (st_reg_write),
        .overflow      (st_overflow),
        .out_ack       (out_ack),
        .res_ready     (res_ready),
        .out_req       (out_req),
        .out_result    (result),
        .out_reg_write (reg_write),
        .out_overflow  (overflow)
    );

endmodule

`default_nettype wire

//--- dv/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;

    import exec_pkg::*;

    localparam int DATA_WIDTH    = 32;
    localparam int SHAMT_WIDTH   = $clog2(DATA_WIDTH);
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_OPS       = 400;
    localparam int CYCLES_PER_OP = 20;
    localparam int TIMEOUT       = (RESET_CYCLES + NUM_OPS * CYCLES_PER_OP) * CLK_PERIOD;
    localparam int DRAIN_CYCLES  = 10;
    localparam int SEED          = 51172;
    localparam int MSB           = DATA_WIDTH - 1;

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    exec_op_t              op;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [IMM_WIDTH-1:0]  imm;
    logic                  imm_signed;
    logic                  use_imm;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic                  shamt_from_reg;
    logic                  out_ack;
    logic                  in_ack;
    logic                  out_req;
    logic [DATA_WIDTH-1:0] result;
    logic                  reg_write;
    logic                  overflow;

    // Expected {overflow, reg_write, result} in issue order
    logic [DATA_WIDTH+1:0] expected_q [$];
    int                    stim_seed;
    int                    delay_seed;
    int                    results_seen;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    exec_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_req         (in_req),
        .op             (op),
        .op_a           (op_a),
        .op_b           (op_b),
        .imm            (imm),
        .imm_signed     (imm_signed),
        .use_imm        (use_imm),
        .shamt          (shamt),
        .shamt_from_reg (shamt_from_reg),
        .out_ack        (out_ack),
        .in_ack         (in_ack),
        .out_req        (out_req),
        .result         (result),
        .reg_write      (reg_write),
        .overflow       (overflow)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] rand_word(inout int s);
        return $random(s);
    endfunction

    function automatic int unsigned rand_below(inout int s, input int unsigned n);
        logic [31:0] r;
        r = $random(s);
        return r % n;
    endfunction

    // Zero, one, all ones and both sign boundaries show up often
    function automatic logic [DATA_WIDTH-1:0] pick_operand(inout int s);
        case (rand_below(s, 8))
            0:       return '0;
            1:       return {1'b0, {(DATA_WIDTH-1){1'b1}}};
            2:       return {1'b1, {(DATA_WIDTH-1){1'b0}}};
            3:       return '1;
            4:       return DATA_WIDTH'(1);
            default: return rand_word(s);
        endcase
    endfunction

    function automatic logic [IMM_WIDTH-1:0] pick_imm(inout int s);
        logic [DATA_WIDTH-1:0] w;
        w = rand_word(s);
        case (rand_below(s, 5))
            0:       return {1'b0, {(IMM_WIDTH-1){1'b1}}};
            1:       return {1'b1, {(IMM_WIDTH-1){1'b0}}};
            2:       return '1;
            3:       return '0;
            default: return w[IMM_WIDTH-1:0];
        endcase
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [DATA_WIDTH+1:0] expected_outcome(
        input exec_op_t               op_code,
        input logic [DATA_WIDTH-1:0]  src_a,
        input logic [DATA_WIDTH-1:0]  src_b,
        input logic [IMM_WIDTH-1:0]   imm_val,
        input logic                   sign_imm,
        input logic                   imm_sel,
        input logic [SHAMT_WIDTH-1:0] shift_val,
        input logic                   shift_sel
    );
        logic [DATA_WIDTH-1:0]  imm_ext;
        logic [DATA_WIDTH-1:0]  alu_b;
        logic [SHAMT_WIDTH-1:0] amt;
        logic [DATA_WIDTH:0]    wide;
        logic [DATA_WIDTH-1:0]  res;
        logic                   wr;
        logic                   ovf;
        imm_ext = sign_imm ? {{(DATA_WIDTH-IMM_WIDTH){imm_val[IMM_WIDTH-1]}}, imm_val}
                           : {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm_val};
        alu_b = imm_sel ? imm_ext : src_b;
        amt   = shift_sel ? src_a[SHAMT_WIDTH-1:0] : shift_val;
        res   = '0;
        wr    = 1'b1;
        ovf   = 1'b0;
        case (op_code)
            // One extra sign bit shows the signed range escape
            OP_ADD, OP_ADDU: begin
                wide = {src_a[MSB], src_a} + {alu_b[MSB], alu_b};
                res  = wide[DATA_WIDTH-1:0];
                ovf  = (op_code == OP_ADD) && (wide[DATA_WIDTH] != wide[DATA_WIDTH-1]);
            end
            OP_SUB, OP_SUBU: begin
                wide = {src_a[MSB], src_a} - {alu_b[MSB], alu_b};
                res  = wide[DATA_WIDTH-1:0];
                ovf  = (op_code == OP_SUB) && (wide[DATA_WIDTH] != wide[DATA_WIDTH-1]);
            end
            OP_AND:  res = src_a & alu_b;
            OP_OR:   res = src_a | alu_b;
            OP_XOR:  res = src_a ^ alu_b;
            OP_NOR:  res = ~(src_a | alu_b);
            OP_SLT:  res = DATA_WIDTH'($signed(src_a) < $signed(alu_b));
            OP_SLTU: res = DATA_WIDTH'(src_a < alu_b);
            // Shifts act on B
            OP_SLL:  res = src_b << amt;
            OP_SRL:  res = src_b >> amt;
            OP_SRA:  res = $signed(src_b) >>> amt;
            OP_MOVZ: begin
                res = src_a;
                wr  = (src_b == '0);
            end
            OP_MOVN: begin
                res = src_a;
                wr  = (src_b != '0);
            end
            default: res = '0;
        endcase
        if (ovf) begin
            wr = 1'b0;
        end
        return {ovf, wr, res};
    endfunction

    ////////////////////
    // Producer
    ////////////////////

    // Full four-phase cycle, entered and left on a falling edge
    task automatic send_op(input exec_op_t c, input logic [DATA_WIDTH-1:0] a,
                           input logic [DATA_WIDTH-1:0] b, input logic [IMM_WIDTH-1:0] i,
                           input logic i_sign, input logic i_sel,
                           input logic [SHAMT_WIDTH-1:0] sh, input logic sh_sel);
        op             = c;
        op_a           = a;
        op_b           = b;
        imm            = i;
        imm_signed     = i_sign;
        use_imm        = i_sel;
        shamt          = sh;
        shamt_from_reg = sh_sel;
        expected_q.push_back(expected_outcome(c, a, b, i, i_sign, i_sel, sh, sh_sel));
        in_req = 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req = 1'b0;
        // Operands free to change once ack is up
        op_a = rand_word(stim_seed);
        op_b = rand_word(stim_seed);
        do @(negedge clk); while (in_ack);
    endtask

    task automatic run_producer();
        logic [DATA_WIDTH-1:0]  w;
        logic [SHAMT_WIDTH-1:0] sh;
        exec_op_t               c;
        // Signed overflow against the unsigned twins, then both move outcomes
        send_op(OP_ADD,  32'h7fff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0, '0, 1'b0);
        send_op(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0, '0, 1'b0);
        send_op(OP_SUB,  32'h8000_0000, 32'h0000_0001, '0, 1'b0, 1'b0, '0, 1'b0);
        send_op(OP_SUBU, 32'h8000_0000, 32'h0000_0001, '0, 1'b0, 1'b0, '0, 1'b0);
        send_op(OP_MOVZ, 32'h1234_5678, 32'h0000_0000, '0, 1'b0, 1'b0, '0, 1'b0);
        send_op(OP_MOVN, 32'h1234_5678, 32'h0000_0000, '0, 1'b0, 1'b0, '0, 1'b0);
        for (int n = 6; n < NUM_OPS; n++) begin
            w  = DATA_WIDTH'(rand_below(stim_seed, 15));
            c  = exec_op_t'(w[3:0]);
            w  = rand_word(stim_seed);
            sh = w[SHAMT_WIDTH-1:0];
            send_op(c, pick_operand(stim_seed), pick_operand(stim_seed), pick_imm(stim_seed),
                    w[8], w[9], sh, w[10]);
        end
    endtask

    ////////////////////
    // Consumer
    ////////////////////

    task automatic run_consumer();
        int unsigned           delay;
        logic [DATA_WIDTH+1:0] exp;
        for (int n = 0; n < NUM_OPS; n++) begin
            do @(negedge clk); while (!out_req);
            // Slow ack builds back-pressure through the pipe
            delay = rand_below(delay_seed, 6);
            repeat (delay) begin
                @(negedge clk);
                assert (out_req) else report_failure("out_req fell before out_ack rose");
            end
            assert (expected_q.size() > 0) else begin
                report_failure("A result arrived with no operation outstanding");
            end
            exp = expected_q.pop_front();
            check_field("result", exp[DATA_WIDTH-1:0], result);
            check_field("reg_write", DATA_WIDTH'(exp[DATA_WIDTH]), DATA_WIDTH'(reg_write));
            check_field("overflow", DATA_WIDTH'(exp[DATA_WIDTH+1]), DATA_WIDTH'(overflow));
            out_ack = 1'b1;
            do @(negedge clk); while (out_req);
            // Ack lingers, request must stay down
            delay = rand_below(delay_seed, 3);
            repeat (delay) begin
                @(negedge clk);
                assert (!out_req) else begin
                    report_failure("out_req rose again while out_ack was still high");
                end
            end
            out_ack = 1'b0;
        end
    endtask

    ////////////////////
    // Result counter
    ////////////////////

    // Each rise of out_req is one delivered result
    initial begin : result_counter
        logic req_prev;
        req_prev     = 1'b0;
        results_seen = 0;
        forever begin
            @(negedge clk);
            if (out_req && !req_prev) begin
                results_seen = results_seen + 1;
            end
            req_prev = out_req;
        end
    end

    ////////////////////
    // Sequence
    ////////////////////

    initial begin : main_seq
        stim_seed      = SEED;
        delay_seed     = SEED;
        rst_n          = 1'b0;
        in_req         = 1'b0;
        op             = OP_ADD;
        op_a           = '0;
        op_b           = '0;
        imm            = '0;
        imm_signed     = 1'b0;
        use_imm        = 1'b0;
        shamt          = '0;
        shamt_from_reg = 1'b0;
        out_ack        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_field("in_ack", '0, DATA_WIDTH'(in_ack));
        check_field("out_req", '0, DATA_WIDTH'(out_req));
        rst_n = 1'b1;
        @(negedge clk);
        check_field("in_ack", '0, DATA_WIDTH'(in_ack));
        check_field("out_req", '0, DATA_WIDTH'(out_req));
        fork
            run_producer();
            run_consumer();
        join
        // Quiet spell so a stray extra result still gets counted
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (results_seen == NUM_OPS) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Counted %0d results for %0d operations", results_seen, NUM_OPS);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // Generous bound on cycles per operation
    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the run did not finish all operations in time");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- list.f
source/exec_pkg.sv
source/alu.sv
source/barrel_shifter.sv
source/op_receiver.sv
source/exec_stage.sv
source/result_sender.sv
source/exec_unit.sv
dv/exec_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exec_unit_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
